//--- Makefile
# Verilator build and run of the serial compute subsystem testbench

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	verilator --binary --timing --assert -f build.f --top-module uart_accel_tb \
		--Mdir obj_dir -o uart_accel_sim
	@out="$$(./obj_dir/uart_accel_sim)"; \
		echo "$$out"; \
		echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

//--- build.f
+incdir+dv
rtl/uart_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/byte_accum.sv
rtl/uart_accel_top.sv
dv/uart_accel_tb.sv

//--- dv/uart_line_tasks.svh
/*
 * serial line tasks for the testbench
 * drive one frame onto rx and capture one reply frame from tx,
 * both timed from the frame constants of the DUT package
 */
`ifndef UART_LINE_TASKS_SVH
`define UART_LINE_TASKS_SVH

// one whole frame in clock cycles
localparam int FRAME_CLKS = uart_pkg::FRAME_BITS * uart_pkg::CLKS_PER_BIT;

// one frame onto rx, bits change on rising edges
task automatic send_frame(input logic [7:0] data, input logic bad_parity,
		input logic stop_low);
	logic [10:0] frame;
	int          i;
	// stop, even parity (optionally inverted), data LSB first, start
	frame = {~stop_low, (^data) ^ bad_parity, data, 1'b0};
	for (i = 0; i < uart_pkg::FRAME_BITS; i++) begin
		@(posedge clk_50mhz);
		rx <= frame[0];
		frame = frame >> 1;
		repeat (uart_pkg::CLKS_PER_BIT - 1) @(posedge clk_50mhz);
	end
	@(posedge clk_50mhz);
	rx <= 1'b1;
	// a low stop bit gets one extra bit time of idle line
	if (stop_low) begin
		repeat (uart_pkg::CLKS_PER_BIT - 1) @(posedge clk_50mhz);
	end
endtask

// one reply frame from tx, sampled on falling edges at each bit centre
task automatic recv_frame(output logic [7:0] data, output logic parity,
		output logic stop);
	int         wait_cnt;
	int         i;
	logic [7:0] shift;
	wait_cnt = 0;
	shift    = '0;
	@(negedge clk_50mhz);
	// hunt for the start bit, three frame times at most
	while (tx !== 1'b0 && wait_cnt < 3 * FRAME_CLKS) begin
		@(negedge clk_50mhz);
		wait_cnt++;
	end
	assert (tx === 1'b0)
		else stop_on_error("no start bit on tx within three frame times");
	repeat (uart_pkg::HALF_BIT) @(negedge clk_50mhz);
	assert (tx === 1'b0)
		else stop_on_error("start bit on tx did not last to its centre");
	// LSB first, shift in from the top
	for (i = 0; i < uart_pkg::DATA_BITS; i++) begin
		repeat (uart_pkg::CLKS_PER_BIT) @(negedge clk_50mhz);
		shift = {tx, shift[7:1]};
	end
	repeat (uart_pkg::CLKS_PER_BIT) @(negedge clk_50mhz);
	parity = tx;
	repeat (uart_pkg::CLKS_PER_BIT) @(negedge clk_50mhz);
	stop = tx;
	data = shift;
endtask

`endif

//--- dv/uart_accel_tb.sv
/*
 * uart_accel_tb
 * testbench for the serial compute subsystem: sends frames on rx,
 * checks each reply on tx against a model of the running sum and
 * tracks the error counter for corrupted frames
 */
`timescale 1ns/1ps
module uart_accel_tb;

	// overall limit for the whole run
	localparam int WATCHDOG_CLKS = 100 * uart_pkg::FRAME_BITS * uart_pkg::CLKS_PER_BIT;

	logic        clk_50mhz;
	logic        rst;
	logic        rx;
	logic        tx;
	logic [7:0]  err_count;

	// model state
	logic [7:0]  model_sum;
	logic [7:0]  err_exp;
	logic        reply_due;

	uart_accel_top u_dut (
		.clk_50mhz (clk_50mhz),
		.rst       (rst),
		.rx        (rx),
		.tx        (tx),
		.err_count (err_count)
	);

	`include "uart_line_tasks.svh"

	initial begin
		clk_50mhz = 1'b0;
		forever #10 clk_50mhz = ~clk_50mhz;
	end

	// report, then stop the run
	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic apply_reset();
		@(posedge clk_50mhz);
		rst <= 1'b1;
		repeat (8) @(posedge clk_50mhz);
		rst <= 1'b0;
		model_sum = '0;
		err_exp   = '0;
	endtask

	// line quiet and error count steady for a number of cycles
	task automatic check_idle(input int cycles);
		int n;
		for (n = 0; n < cycles; n++) begin
			@(negedge clk_50mhz);
			assert (tx === 1'b1)
				else stop_on_error($sformatf("FAIL tx: got 0x%h expected 0x1", tx));
			assert (err_count === err_exp)
				else stop_on_error($sformatf("FAIL err_count: got 0x%02h expected 0x%02h",
					err_count, err_exp));
		end
	endtask

	// good byte out, reply with the new running sum back
	task automatic exchange(input logic [7:0] value);
		logic [7:0] got_data;
		logic       got_par;
		logic       got_stop;
		logic [7:0] expected;
		expected  = model_sum + value;
		model_sum = expected;
		reply_due = 1'b1;
		fork
			send_frame(value, 1'b0, 1'b0);
			recv_frame(got_data, got_par, got_stop);
		join
		reply_due = 1'b0;
		assert (got_data === expected)
			else stop_on_error($sformatf("FAIL tx data: got 0x%02h expected 0x%02h",
				got_data, expected));
		// even parity over data plus parity bit
		assert (got_par === ^expected)
			else stop_on_error($sformatf("FAIL tx parity: got 0x%h expected 0x%h",
				got_par, ^expected));
		assert (got_stop === 1'b1)
			else stop_on_error($sformatf("FAIL tx stop: got 0x%h expected 0x1", got_stop));
		assert (err_count === err_exp)
			else stop_on_error($sformatf("FAIL err_count: got 0x%02h expected 0x%02h",
				err_count, err_exp));
	endtask

	// corrupted frame, no reply and one more error
	task automatic reject(input logic [7:0] value, input logic bad_parity,
			input logic stop_low);
		send_frame(value, bad_parity, stop_low);
		if (err_exp != 8'hff) begin
			err_exp = err_exp + 8'd1;
		end
		check_idle(2 * FRAME_CLKS);
	endtask

	// tx must stay idle whenever no reply is outstanding
	assert property (@(posedge clk_50mhz) disable iff (rst) !reply_due |-> tx)
		else stop_on_error("tx left its idle level while no reply was due");

	initial begin
		repeat (WATCHDOG_CLKS) @(posedge clk_50mhz);
		stop_on_error("run did not finish within its overall time limit");
	end

	initial begin
		logic [31:0] rnd;
		logic [7:0]  value;
		int          i;
		rst        = 1'b1;
		rx         = 1'b1;
		model_sum  = '0;
		err_exp    = '0;
		reply_due  = 1'b0;
		rnd        = $urandom(27);

		apply_reset();
		check_idle(FRAME_CLKS);

		// reference bytes, sums 01 03 06 0a
		exchange(8'h01);
		exchange(8'h02);
		exchange(8'h03);
		exchange(8'h04);

		// random bytes, with f0 then 20 forcing a wrap past ff
		for (i = 0; i < 12; i++) begin
			rnd   = $urandom();
			value = rnd[7:0];
			if (i == 4) begin
				value = 8'hf0;
			end else if (i == 5) begin
				value = 8'h20;
			end
			exchange(value);
		end

		// flipped parity, then the sum must be unchanged
		reject(8'h3c, 1'b1, 1'b0);
		exchange(8'h11);

		// low stop bit, same outcome
		reject(8'hc5, 1'b0, 1'b1);
		exchange(8'h22);

		// reset between frames clears the count and the sum
		apply_reset();
		check_idle(uart_pkg::CLKS_PER_BIT);
		exchange(8'h5a);

		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- rtl/byte_accum.sv
/*
 * byte_accum
 * compute stand-in for the core: adds each good received byte to a
 * running 8-bit sum and asks the transmitter to send the new sum;
 * bad frames only bump a saturating error counter
 */
`timescale 1ns/1ps
module byte_accum (
	input  logic                clk_50mhz,
	input  logic                rst,
	input  logic                rx_req,
	output logic                rx_ack,
	input  uart_pkg::rx_frame_t rx_frame,
	output logic                tx_req,
	input  logic                tx_ack,
	output uart_pkg::tx_byte_t  tx_byte,
	output logic [7:0]          err_count
);

	logic [uart_pkg::DATA_BITS-1:0] sum;
	logic                           accept;
	logic                           good;

	// take a frame only when the tx channel is fully closed,
	// otherwise ack is held back and the receiver waits
	assign accept = rx_req && !rx_ack && !tx_req && !tx_ack;

	// both checks must pass for the byte to count
	assign good = !rx_frame.parity_err && !rx_frame.stop_err;

	always_ff @(posedge clk_50mhz) begin
		if (rst) begin
			rx_ack    <= 1'b0;
			tx_req    <= 1'b0;
			sum       <= '0;
			err_count <= '0;
		end else begin
			// rx side handshake
			if (accept) begin
				rx_ack <= 1'b1;
			end else if (!rx_req && rx_ack) begin
				rx_ack <= 1'b0;
			end

			// good byte: new sum, wraps mod 256, and request a reply
			if (accept && good) begin
				sum    <= sum + rx_frame.data;
				tx_req <= 1'b1;
			end else if (tx_req && tx_ack) begin
				tx_req <= 1'b0;
			end

			// bad frame: sum untouched, count it
			if (accept && !good && err_count != 8'hff) begin
				err_count <= err_count + 1'b1;
			end
		end
	end

	// sum cannot change while tx_req is high, so it is the payload
	assign tx_byte.data = sum;

endmodule

//--- rtl/uart_accel_top.sv
/*
 * uart_accel_top
 * serial compute subsystem: receiver, running-sum block and
 * transmitter joined by two four-phase req/ack channels
 */
`timescale 1ns/1ps
module uart_accel_top (
	input  logic       clk_50mhz,
	input  logic       rst,
	input  logic       rx,
	output logic       tx,
	output logic [7:0] err_count
);

	// rx to accum channel
	logic                rx_req;
	logic                rx_ack;
	uart_pkg::rx_frame_t rx_frame;

	// accum to tx channel
	logic               tx_req;
	logic               tx_ack;
	uart_pkg::tx_byte_t tx_byte;

	uart_rx u_rx (
		.clk_50mhz (clk_50mhz),
		.rst       (rst),
		.rx        (rx),
		.rx_req    (rx_req),
		.rx_ack    (rx_ack),
		.rx_frame  (rx_frame)
	);

	byte_accum u_accum (
		.clk_50mhz (clk_50mhz),
		.rst       (rst),
		.rx_req    (rx_req),
		.rx_ack    (rx_ack),
		.rx_frame  (rx_frame),
		.tx_req    (tx_req),
		.tx_ack    (tx_ack),
		.tx_byte   (tx_byte),
		.err_count (err_count)
	);

	uart_tx u_tx (
		.clk_50mhz (clk_50mhz),
		.rst       (rst),
		.tx_req    (tx_req),
		.tx_ack    (tx_ack),
		.tx_byte   (tx_byte),
		.tx        (tx)
	);

endmodule

//--- rtl/uart_pkg.sv
/*
 * uart_pkg
 * shared serial frame constants, counter types and the payload
 * structs passed between receiver, compute block and transmitter
 */
package uart_pkg;

	// line timing at clk_50mhz, about 96 kbaud
	localparam int CLKS_PER_BIT = 521;
	// centre of the start bit, counted from its falling edge
	localparam int HALF_BIT = CLKS_PER_BIT / 2;

	// frame layout: start, data LSB first, even parity, stop
	localparam int DATA_BITS = 8;
	localparam int FRAME_BITS = DATA_BITS + 3;

	// counter widths
	localparam int BAUD_W = $clog2(CLKS_PER_BIT);
	localparam int RX_BIT_W = $clog2(DATA_BITS);
	localparam int TX_BIT_W = $clog2(FRAME_BITS);

	// baud counter, wide enough for one full bit time
	typedef logic [BAUD_W-1:0] baud_cnt_t;

	// data bit index inside the receiver
	typedef logic [RX_BIT_W-1:0] rx_bit_cnt_t;

	// frame bit index inside the transmitter
	typedef logic [TX_BIT_W-1:0] tx_bit_cnt_t;

	// received frame as offered by the receiver
	// error flags travel with the data, the consumer decides what to do
	typedef struct packed {
		logic [DATA_BITS-1:0] data;
		logic                 parity_err;
		logic                 stop_err;
	} rx_frame_t;

	// byte handed to the transmitter
	typedef struct packed {
		logic [DATA_BITS-1:0] data;
	} tx_byte_t;

endpackage

//--- rtl/uart_rx.sv
/*
 * uart_rx
 * serial receiver for frames of one start bit, eight data bits
 * LSB first, even parity and one stop bit; samples every bit at
 * its centre and offers the checked frame on a four-phase req/ack
 */
`timescale 1ns/1ps
module uart_rx (
	input  logic                clk_50mhz,
	input  logic                rst,
	input  logic                rx,
	output logic                rx_req,
	input  logic                rx_ack,
	output uart_pkg::rx_frame_t rx_frame
);

	typedef enum logic [2:0] {
		s_idle,
		s_start,
		s_data,
		s_parity,
		s_stop,
		s_offer
	} rx_state_t;

	rx_state_t                     state;
	logic                          rx_meta;
	logic                          rx_sync;
	uart_pkg::baud_cnt_t           baud_cnt;
	uart_pkg::rx_bit_cnt_t         bit_cnt;
	logic                          half_end;
	logic                          bit_end;
	logic [uart_pkg::DATA_BITS-1:0] data_sr;
	logic                          parity_err;
	logic                          stop_err;

	// two-flop synchronizer, line idles high
	always_ff @(posedge clk_50mhz) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	// centre of start bit, then one full bit time to each following centre
	assign half_end = (baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::HALF_BIT - 1));
	assign bit_end  = (baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::CLKS_PER_BIT - 1));

	// frame FSM
	always_ff @(posedge clk_50mhz) begin
		if (rst) begin
			state    <= s_idle;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			rx_req   <= 1'b0;
		end else begin
			case (state)
				s_idle: begin
					baud_cnt <= '0;
					// falling edge marks a possible start bit
					if (!rx_sync) begin
						state <= s_start;
					end
				end
				s_start: begin
					if (half_end) begin
						baud_cnt <= '0;
						bit_cnt  <= '0;
						// line back high at the centre, just a glitch
						state    <= rx_sync ? s_idle : s_data;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				s_data: begin
					if (bit_end) begin
						baud_cnt <= '0;
						bit_cnt  <= bit_cnt + 1'b1;
						if (bit_cnt == uart_pkg::rx_bit_cnt_t'(uart_pkg::DATA_BITS - 1)) begin
							state <= s_parity;
						end
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				s_parity: begin
					if (bit_end) begin
						baud_cnt <= '0;
						state    <= s_stop;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				s_stop: begin
					if (bit_end) begin
						baud_cnt <= '0;
						// offer the frame right after the stop sample
						rx_req   <= 1'b1;
						state    <= s_offer;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				s_offer: begin
					// drop req once ack is seen, then wait for ack low
					// before hunting for the next start bit
					if (rx_req && rx_ack) begin
						rx_req <= 1'b0;
					end else if (!rx_req && !rx_ack) begin
						state <= s_idle;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	// payload capture, held while the frame is offered
	always_ff @(posedge clk_50mhz) begin
		if (state == s_data && bit_end) begin
			// LSB arrives first, shift in from the top
			data_sr <= {rx_sync, data_sr[uart_pkg::DATA_BITS-1:1]};
		end
		if (state == s_parity && bit_end) begin
			// even parity: data xor parity bit must be zero
			parity_err <= rx_sync ^ (^data_sr);
		end
		if (state == s_stop && bit_end) begin
			stop_err <= ~rx_sync;
		end
	end

	assign rx_frame.data       = data_sr;
	assign rx_frame.parity_err = parity_err;
	assign rx_frame.stop_err   = stop_err;

endmodule

//--- rtl/uart_tx.sv
/*
 * uart_tx
 * serializer that takes a byte over a four-phase req/ack and sends
 * it as start bit, data LSB first, even parity and stop bit
 */
`timescale 1ns/1ps
module uart_tx (
	input  logic               clk_50mhz,
	input  logic               rst,
	input  logic               tx_req,
	output logic               tx_ack,
	input  uart_pkg::tx_byte_t tx_byte,
	output logic               tx
);

	typedef enum logic {
		s_idle,
		s_send
	} tx_state_t;

	tx_state_t                       state;
	uart_pkg::baud_cnt_t             baud_cnt;
	uart_pkg::tx_bit_cnt_t           bit_cnt;
	logic [uart_pkg::FRAME_BITS-1:0] shift_q;
	logic                            load;
	logic                            bit_end;

	// new request only while idle and the previous handshake is closed
	assign load    = (state == s_idle) && tx_req && !tx_ack;
	assign bit_end = (baud_cnt == uart_pkg::baud_cnt_t'(uart_pkg::CLKS_PER_BIT - 1));

	always_ff @(posedge clk_50mhz) begin
		if (rst) begin
			state    <= s_idle;
			tx_ack   <= 1'b0;
			tx       <= 1'b1;
			baud_cnt <= '0;
			bit_cnt  <= '0;
		end else begin
			// ack rises with the load, falls one cycle after req drops
			if (load) begin
				tx_ack <= 1'b1;
			end else if (!tx_req && tx_ack) begin
				tx_ack <= 1'b0;
			end

			// registered line, start bit appears the edge after load
			tx <= (state == s_send) ? shift_q[0] : 1'b1;

			case (state)
				s_idle: begin
					if (load) begin
						baud_cnt <= '0;
						bit_cnt  <= '0;
						state    <= s_send;
					end
				end
				s_send: begin
					if (bit_end) begin
						baud_cnt <= '0;
						bit_cnt  <= bit_cnt + 1'b1;
						// stop bit done
						if (bit_cnt == uart_pkg::tx_bit_cnt_t'(uart_pkg::FRAME_BITS - 1)) begin
							state <= s_idle;
						end
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	// frame shift register, bit 0 is the one on the line
	always_ff @(posedge clk_50mhz) begin
		if (load) begin
			// stop, even parity, data, start
			shift_q <= {1'b1, ^tx_byte.data, tx_byte.data, 1'b0};
		end else if (state == s_send && bit_end) begin
			// fill with idle level behind the frame
			shift_q <= {1'b1, shift_q[uart_pkg::FRAME_BITS-1:1]};
		end
	end

endmodule
